// ==== periph_pkg.sv ====
// XT peripheral glue logic shared definitions
// Bus widths, port map constants and the EMS command byte layout
`default_nettype none

package periph_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [15:0] io_addr_t;
    typedef logic [19:0] mem_addr_t;
    typedef logic [6:0]  ems_page_t;
    typedef logic [1:0]  ems_slot_t;

    // Byte written to an EMS page port
    // FFh disables the slot, keep clear maps a new page
    typedef union packed {
        data_t raw;
        struct packed {
            logic      keep;
            ems_page_t page;
        } fields;
    } ems_cmd_u;

    localparam data_t ems_disable_code = 8'hFF;

    localparam int ems_slots = 4;

    // NMI mask register answers A0h-A7h
    localparam io_addr_t nmi_port_base = 16'h00A0;

    localparam data_t lpt_reset_value = 8'hFF;
    localparam data_t nmi_reset_value = 8'hFF;

endpackage

`default_nettype wire

// ==== io_decode.sv ====
// I/O address decoder for the XT peripheral board
// Produces device selects and the two DMA chip selects
`default_nettype none

module io_decode
    import periph_pkg::*;
#(
    parameter io_addr_t ems_port_base = 16'h0260,
    parameter io_addr_t lpt_port      = 16'h0378
) (
    input  wire mem_addr_t address_i,
    input  wire            io_read_n_i,
    input  wire            io_write_n_i,
    input  wire            address_enable_n_i,
    input  wire            ems_enabled_i,
    input  wire            tandy_video_i,
    output logic           ems_sel_o,
    output logic           lpt_sel_o,
    output logic           nmi_sel_o,
    output logic           dma_chip_select_n_o,
    output logic           dma_page_chip_select_n_o
);

    io_addr_t   port;
    io_addr_t   ems_offset;
    logic       iorq;
    logic       bus_cycle;
    logic [7:0] low_block;

    assign port       = address_i[15:0];
    assign ems_offset = port - ems_port_base;
    assign iorq       = ~io_read_n_i | ~io_write_n_i;
    assign bus_cycle  = iorq & ~address_enable_n_i;

    // Ports 000h-0FFh split into 32-byte blocks
    always_comb begin
        low_block = 8'h00;
        if (bus_cycle && port[9:8] == 2'b00) begin
            low_block[port[7:5]] = 1'b1;
        end
    end

    // DMA controller at 000h, page registers at 080h
    assign dma_chip_select_n_o      = ~low_block[0];
    assign dma_page_chip_select_n_o = ~low_block[4];

    // Four EMS page ports from the jumpered base
    assign ems_sel_o = bus_cycle & ems_enabled_i & (ems_offset < 16'd4);

    assign lpt_sel_o = bus_cycle & (port == lpt_port);

    // NMI mask only exists on Tandy configurations
    assign nmi_sel_o = bus_cycle & tandy_video_i & (port[15:3] == nmi_port_base[15:3]);

    // Overlapping jumper settings would drive two devices at once
    always_comb begin
        assert ($onehot0({ems_sel_o, lpt_sel_o, nmi_sel_o}))
            else $error("io_decode: more than one device select active");
    end

endmodule

`default_nettype wire

// ==== ems_mapper.sv ====
// EMS page mapper
// Four page registers with enables, written through a one-stage pipeline,
// with readback and memory window hit decoding
`default_nettype none

module ems_mapper
    import periph_pkg::*;
(
    input  wire                  clock,
    input  wire                  reset,
    input  wire mem_addr_t       address_i,
    input  wire data_t           data_i,
    input  wire                  io_write_n_i,
    input  wire                  io_read_n_i,
    input  wire                  ems_sel_i,
    input  wire [1:0]            ems_address_i,
    output data_t                ems_read_value_o,
    output logic [ems_slots-1:0] ems_hit_o
);

    localparam ems_page_t disabled_page = 7'h7F;

    ems_page_t            page_q [ems_slots];
    logic [ems_slots-1:0] enable_q;

    ems_cmd_u  cmd;
    ems_slot_t slot;
    ems_page_t next_page;
    logic      next_enable;
    logic      iorq;
    logic      [3:0] window_base;

    logic      wr_q;
    ems_slot_t wr_slot_q;
    ems_page_t wr_page_q;
    logic      wr_enable_q;

    assign slot = address_i[1:0];
    assign cmd  = ems_cmd_u'(data_i);
    assign iorq = ~io_read_n_i | ~io_write_n_i;

    // Resolve the new slot contents before the pipeline stage
    always_comb begin
        if (cmd.raw == ems_disable_code) begin
            next_page   = disabled_page;
            next_enable = 1'b0;
        end else if (!cmd.fields.keep) begin
            next_page   = cmd.fields.page;
            next_enable = 1'b1;
        end else begin
            next_page   = page_q[slot];
            next_enable = enable_q[slot];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= ems_sel_i & ~io_write_n_i;
        end
    end

    always_ff @(posedge clock) begin
        wr_slot_q   <= slot;
        wr_page_q   <= next_page;
        wr_enable_q <= next_enable;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_q   <= '{default: '0};
            enable_q <= '0;
        end else if (wr_q) begin
            page_q[wr_slot_q]   <= wr_page_q;
            enable_q[wr_slot_q] <= wr_enable_q;
        end
    end

    // Disabled slots read back as FFh
    assign ems_read_value_o = enable_q[slot] ? {1'b0, page_q[slot]} : 8'hFF;

    // Window at A0000h, C0000h or D0000h, 16 KB per slot
    always_comb begin
        case (ems_address_i)
            2'd0:    window_base = 4'hA;
            2'd1:    window_base = 4'hC;
            default: window_base = 4'hD;
        endcase
    end

    always_comb begin
        for (int k = 0; k < ems_slots; k++) begin
            ems_hit_o[k] = ~iorq & enable_q[k]
                & (address_i[19:14] == {window_base, ems_slot_t'(k)});
        end
    end

    assert property (@(posedge clock) disable iff (reset) $onehot0(ems_hit_o))
        else $error("ems_mapper: more than one EMS window hit");

    assert property (@(posedge clock) disable iff (reset)
        wr_q |-> (int'(wr_slot_q) < ems_slots))
        else $error("ems_mapper: pipeline write to slot out of range");

endmodule

`default_nettype wire

// ==== io_latch_regs.sv ====
// Latched I/O registers
// Parallel-port data latch and Tandy NMI mask register
`default_nettype none

module io_latch_regs
    import periph_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire data_t data_i,
    input  wire        io_write_n_i,
    input  wire        lpt_sel_i,
    input  wire        nmi_sel_i,
    output data_t      lpt_value_o,
    output data_t      nmi_value_o
);

    logic lpt_write;
    logic nmi_write;

    assign lpt_write = lpt_sel_i & ~io_write_n_i;
    assign nmi_write = nmi_sel_i & ~io_write_n_i;

    // Both registers come up all ones
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_value_o <= lpt_reset_value;
            nmi_value_o <= nmi_reset_value;
        end else begin
            if (lpt_write) begin
                lpt_value_o <= data_i;
            end
            if (nmi_write) begin
                nmi_value_o <= data_i;
            end
        end
    end

    // Decoder must never select both latches in one cycle
    assert property (@(posedge clock) disable iff (reset) !(lpt_write && nmi_write))
        else $error("io_latch_regs: LPT and NMI written on the same edge");

endmodule

`default_nettype wire

// ==== read_data_mux.sv ====
// Registered read-data multiplexer
// Picks EMS, LPT or NMI data for an I/O read, one cycle after sampling
`default_nettype none

module read_data_mux
    import periph_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire        io_read_n_i,
    input  wire        ems_sel_i,
    input  wire        lpt_sel_i,
    input  wire        nmi_sel_i,
    input  wire data_t ems_value_i,
    input  wire data_t lpt_value_i,
    input  wire data_t nmi_value_i,
    output data_t      data_bus_out_o,
    output logic       data_bus_out_from_chipset_o
);

    logic reading;

    assign reading = ~io_read_n_i;

    // Priority EMS, then LPT, then NMI
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_bus_out_o              <= '0;
            data_bus_out_from_chipset_o <= 1'b0;
        end else if (reading && ems_sel_i) begin
            data_bus_out_o              <= ems_value_i;
            data_bus_out_from_chipset_o <= 1'b1;
        end else if (reading && lpt_sel_i) begin
            data_bus_out_o              <= lpt_value_i;
            data_bus_out_from_chipset_o <= 1'b1;
        end else if (reading && nmi_sel_i) begin
            data_bus_out_o              <= nmi_value_i;
            data_bus_out_from_chipset_o <= 1'b1;
        end else begin
            data_bus_out_o              <= '0;
            data_bus_out_from_chipset_o <= 1'b0;
        end
    end

    // Bus stays quiet while the board is not driving it
    assert property (@(posedge clock) disable iff (reset)
        !data_bus_out_from_chipset_o |-> (data_bus_out_o == '0))
        else $error("read_data_mux: data on bus without valid flag");

endmodule

`default_nettype wire

// ==== peripherals_top.sv ====
// XT peripheral board glue logic top level
// Address decoder, EMS mapper, I/O latches and read-data mux
`default_nettype none

module peripherals_top
    import periph_pkg::*;
#(
    parameter io_addr_t ems_port_base = 16'h0260,
    parameter io_addr_t lpt_port      = 16'h0378
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire mem_addr_t       address_i,
    input  wire data_t           data_i,
    input  wire                  io_read_n_i,
    input  wire                  io_write_n_i,
    input  wire                  memory_read_n_i,
    input  wire                  address_enable_n_i,
    input  wire                  ems_enabled_i,
    input  wire [1:0]            ems_address_i,
    input  wire                  tandy_video_i,
    output logic                 dma_chip_select_n_o,
    output logic                 dma_page_chip_select_n_o,
    output logic [ems_slots-1:0] ems_hit_o,
    output data_t                data_bus_out_o,
    output logic                 data_bus_out_from_chipset_o
);

    // Memory read strobe is part of the board bus
    // EMS windows decode from address and iorq alone

    logic  ems_sel;
    logic  lpt_sel;
    logic  nmi_sel;
    data_t ems_read_value;
    data_t lpt_value;
    data_t nmi_value;

    io_decode #(
        .ems_port_base (ems_port_base),
        .lpt_port      (lpt_port)
    ) u_io_decode (
        .address_i                (address_i),
        .io_read_n_i              (io_read_n_i),
        .io_write_n_i             (io_write_n_i),
        .address_enable_n_i       (address_enable_n_i),
        .ems_enabled_i            (ems_enabled_i),
        .tandy_video_i            (tandy_video_i),
        .ems_sel_o                (ems_sel),
        .lpt_sel_o                (lpt_sel),
        .nmi_sel_o                (nmi_sel),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o)
    );

    ems_mapper u_ems_mapper (
        .clock            (clock),
        .reset            (reset),
        .address_i        (address_i),
        .data_i           (data_i),
        .io_write_n_i     (io_write_n_i),
        .io_read_n_i      (io_read_n_i),
        .ems_sel_i        (ems_sel),
        .ems_address_i    (ems_address_i),
        .ems_read_value_o (ems_read_value),
        .ems_hit_o        (ems_hit_o)
    );

    io_latch_regs u_io_latch_regs (
        .clock        (clock),
        .reset        (reset),
        .data_i       (data_i),
        .io_write_n_i (io_write_n_i),
        .lpt_sel_i    (lpt_sel),
        .nmi_sel_i    (nmi_sel),
        .lpt_value_o  (lpt_value),
        .nmi_value_o  (nmi_value)
    );

    read_data_mux u_read_data_mux (
        .clock                       (clock),
        .reset                       (reset),
        .io_read_n_i                 (io_read_n_i),
        .ems_sel_i                   (ems_sel),
        .lpt_sel_i                   (lpt_sel),
        .nmi_sel_i                   (nmi_sel),
        .ems_value_i                 (ems_read_value),
        .lpt_value_i                 (lpt_value),
        .nmi_value_i                 (nmi_value),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

`default_nettype wire

// ==== tb_peripherals.sv ====
// Testbench for the XT peripheral glue logic
// Replays bus transactions from periph_input.txt and checks the board's responses
`default_nettype none

module tb_peripherals;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string input_file = "periph_input.txt";

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  data;
    logic        io_read_n;
    logic        io_write_n;
    logic        memory_read_n;
    logic        address_enable_n;
    logic        ems_enabled;
    logic [1:0]  ems_address;
    logic        tandy_video;
    logic        dma_chip_select_n;
    logic        dma_page_chip_select_n;
    logic [3:0]  ems_hit;
    logic [7:0]  data_bus_out;
    logic        data_bus_out_from_chipset;

    int          errors = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    peripherals_top i_peripherals_top (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .address_enable_n_i          (address_enable_n),
        .ems_enabled_i               (ems_enabled),
        .ems_address_i               (ems_address),
        .tandy_video_i               (tandy_video),
        .dma_chip_select_n_o         (dma_chip_select_n),
        .dma_page_chip_select_n_o    (dma_page_chip_select_n),
        .ems_hit_o                   (ems_hit),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // Watchdog limit set once the stimulus length is known
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic count_lines(output int count);
        int    fd;
        string line;
        count = 0;
        fd = $fopen(input_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                count++;
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
            else begin
                errors++;
                $display("FAIL %s expected %0h actual %0h", name, expected, actual);
                $display("Something failed");
                $fatal(1, "check failed");
            end
    endtask

    // All strobes inactive between transactions
    task automatic go_idle();
        io_read_n        <= 1'b1;
        io_write_n       <= 1'b1;
        memory_read_n    <= 1'b1;
        address_enable_n <= 1'b1;
    endtask

    task automatic set_bus(input logic [31:0] en, input logic [31:0] tv,
                           input logic [31:0] ea, input logic [31:0] addr,
                           input logic [31:0] dat);
        ems_enabled <= en[0];
        tandy_video <= tv[0];
        ems_address <= ea[1:0];
        address     <= addr[19:0];
        data        <= dat[7:0];
    endtask

    task automatic run_transaction(input string name, input byte op,
                                   input logic [31:0] en, input logic [31:0] tv,
                                   input logic [31:0] ea, input logic [31:0] addr,
                                   input logic [31:0] dat, input logic [31:0] expected);
        @(posedge clock);
        set_bus(en, tv, ea, addr, dat);
        case (op)
            "W": begin
                io_write_n       <= 1'b0;
                address_enable_n <= 1'b0;
                @(posedge clock);
                go_idle();
            end
            "R": begin
                io_read_n        <= 1'b0;
                address_enable_n <= 1'b0;
                @(posedge clock);
                go_idle();
                // Read data registered on the sampling edge
                @(negedge clock);
                check_value(name, {23'd0, expected[8:0]},
                            {23'd0, data_bus_out_from_chipset, data_bus_out});
            end
            "M": begin
                memory_read_n    <= 1'b0;
                io_read_n        <= ~dat[0];
                address_enable_n <= 1'b0;
                @(negedge clock);
                check_value(name, {28'd0, expected[3:0]}, {28'd0, ems_hit});
                @(posedge clock);
                go_idle();
            end
            "D": begin
                io_read_n        <= 1'b0;
                address_enable_n <= dat[0];
                @(negedge clock);
                check_value(name, {30'd0, expected[1:0]},
                            {30'd0, dma_chip_select_n, dma_page_chip_select_n});
                @(posedge clock);
                go_idle();
            end
            default: begin
                $display("Unknown operation letter in %s", name);
                $display("Something failed");
                $fatal(1, "bad stimulus");
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          fields;
        int          line_count;
        string       line;
        string       name;
        byte         op;
        logic [31:0] en;
        logic [31:0] tv;
        logic [31:0] ea;
        logic [31:0] addr;
        logic [31:0] dat;
        logic [31:0] expected;

        reset            = 1'b1;
        address          = '0;
        data             = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        address_enable_n = 1'b1;
        ems_enabled      = 1'b0;
        ems_address      = 2'd0;
        tandy_video      = 1'b0;

        count_lines(line_count);
        cycle_limit = 3 * line_count + 20;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", input_file);
            $display("Something failed");
            $fatal(1, "no stimulus");
        end

        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            op = line.getc(0);
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                             en, tv, ea, addr, dat, expected);
            if (fields != 6) begin
                $display("Line %0d of the stimulus file is malformed", line_no);
                $display("Something failed");
                $fatal(1, "bad stimulus");
            end
            name = $sformatf("line %0d %c %05h", line_no, op, addr[19:0]);
            run_transaction(name, op, en, tv, ea, addr, dat, expected);
        end
        $fclose(fd);

        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== periph_input.txt ====
# op ems_enabled tandy_video ems_address address data expected, all hex; R expects {valid, byte}
# M: data bit0 pulls io_read_n low, expects ems_hit; D: data bit0 raises address_enable_n
R 0 0 0 00378 00 1FF
R 0 1 0 000A3 00 1FF
R 1 0 0 00260 00 1FF
R 1 0 0 00261 00 1FF
R 1 0 0 00262 00 1FF
R 1 0 0 00263 00 1FF
W 0 0 0 00378 5A 000
R 0 0 0 00378 00 15A
R 0 0 0 00379 00 000
W 0 1 0 000A3 3C 000
R 0 1 0 000A3 00 13C
W 0 0 0 000A3 81 000
R 0 0 0 000A3 00 000
R 0 1 0 000A3 00 13C
W 1 0 0 00260 05 000
R 1 0 0 00260 00 105
W 1 0 0 00260 9A 000
R 1 0 0 00260 00 105
W 1 0 0 00260 FF 000
R 1 0 0 00260 00 1FF
W 0 0 0 00261 12 000
R 1 0 0 00261 00 1FF
W 1 0 0 00261 21 000
W 1 0 0 00262 42 000
W 1 0 0 00263 7F 000
R 1 0 0 00263 00 17F
M 0 0 0 A4000 00 2
M 0 0 0 A8000 00 4
M 0 0 0 AC000 00 8
M 0 0 0 A0000 00 0
M 0 0 0 C4000 00 0
M 0 0 1 C4000 00 2
M 0 0 1 CBFFF 00 4
M 0 0 2 DC123 00 8
M 0 0 2 D4000 01 0
D 0 0 0 00010 00 1
D 0 0 0 00085 00 2
D 0 0 0 00110 00 3
D 0 0 0 00010 01 3

// ==== filelist.f ====
periph_pkg.sv
io_decode.sv
ems_mapper.sv
io_latch_regs.sv
read_data_mux.sv
peripherals_top.sv
tb_peripherals.sv

// ==== Makefile ====
# Verilator simulation of the XT peripheral glue logic
TOP := tb_peripherals

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
